/* source/rename_pkg.sv */
/*
 * rename_pkg
 * Sizes, register-type and exception codes, and the packed structs
 * shared by the register-rename blocks of a two-wide dispatch core.
 */
package rename_pkg;

  localparam int DISP_SIZE     = 2;   // slots per dispatch group.
  localparam int NUM_AREGS     = 32;
  localparam int XPR_RNID_SIZE = 48;
  localparam int FPR_RNID_SIZE = 40;
  localparam int RNID_W        = $clog2(XPR_RNID_SIZE > FPR_RNID_SIZE ?
                                        XPR_RNID_SIZE : FPR_RNID_SIZE);
  localparam int REG_IDX_W     = $clog2(NUM_AREGS);
  localparam int CQ_DEPTH      = 8;   // groups waiting for commit.

  typedef enum logic [1:0] {
    NONE = 2'd0,
    GPR  = 2'd1,
    FPR  = 2'd2
  } reg_typ_t;

  typedef enum logic [1:0] {
    NO_EXCEPT    = 2'd0,
    SILENT_FLUSH = 2'd1,   // slot still commits.
    TRAP         = 2'd2
  } except_t;

  typedef logic [RNID_W-1:0]    rnid_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  typedef struct packed {
    reg_typ_t rd_typ;
    reg_idx_t rd_regidx;
    reg_typ_t rs1_typ;
    reg_idx_t rs1_regidx;
  } disp_slot_t;

  typedef struct packed {
    logic                        valid;
    disp_slot_t [DISP_SIZE-1:0] slot;
  } disp_grp_t;

  typedef struct packed {
    logic                   valid;
    rnid_t [DISP_SIZE-1:0] rd_rnid;
    rnid_t [DISP_SIZE-1:0] rs1_rnid;
  } rename_res_t;

  typedef struct packed {
    logic    commit;
    grp_id_t dead_id;
    grp_id_t except_valid;
    except_t except_type;
  } cmt_req_t;

  typedef struct packed {
    logic                      commit;
    grp_id_t                   rnid_valid;
    reg_typ_t [DISP_SIZE-1:0] rd_typ;
    reg_idx_t [DISP_SIZE-1:0] rd_regidx;
    rnid_t [DISP_SIZE-1:0]    rd_rnid;
    rnid_t [DISP_SIZE-1:0]    old_rnid;
    grp_id_t                   dead_id;
    grp_id_t                   except_valid;
    except_t                   except_type;
  } cmt_rnid_upd_t;

  // x0 and typeless destinations never take an rnid.
  function automatic logic rd_write(disp_slot_t slot);
    return (slot.rd_typ == FPR) || (slot.rd_typ == GPR && slot.rd_regidx != '0);
  endfunction

  // slots whose own result is thrown away at commit.
  function automatic grp_id_t killed(cmt_rnid_upd_t upd);
    return upd.dead_id | (upd.except_valid & {DISP_SIZE{upd.except_type != SILENT_FLUSH}});
  endfunction

endpackage

/* source/commit_map.sv */
/*
 * commit_map
 * Architectural rename map of one register file. Commit notifications
 * write the new rnid of every live slot of the matching type.
 */
`timescale 1ns/1ps

module commit_map #(
  parameter rename_pkg::reg_typ_t REG_TYPE = rename_pkg::GPR,
  parameter type rnid_t = logic [rename_pkg::RNID_W-1:0]
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rename_pkg::cmt_rnid_upd_t i_commit_rnid_update,
  output rnid_t                     o_rnid_map [rename_pkg::NUM_AREGS]
);
  import rename_pkg::*;

  rnid_t   r_map      [NUM_AREGS];
  rnid_t   w_map_next [NUM_AREGS];
  grp_id_t w_killed;

  always_comb begin
    w_killed   = killed(i_commit_rnid_update);
    w_map_next = r_map;
    if (i_commit_rnid_update.commit) begin
      for (int d = 0; d < DISP_SIZE; d++) begin   // later slot wins.
        if (i_commit_rnid_update.rnid_valid[d] &&
            i_commit_rnid_update.rd_typ[d] == REG_TYPE && !w_killed[d]) begin
          w_map_next[i_commit_rnid_update.rd_regidx[d]] =
            rnid_t'(i_commit_rnid_update.rd_rnid[d]);
        end
      end
    end
  end

  for (genvar r = 0; r < NUM_AREGS; r++) begin : g_map
    if (REG_TYPE == GPR && r == 0) begin : g_zero
      assign r_map[r] = '0;   // x0 is pinned to rnid 0.
    end else begin : g_reg
      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_map[r] <= rnid_t'(r);   // identity mapping.
        end else begin
          r_map[r] <= w_map_next[r];
        end
      end
    end
    assign o_rnid_map[r] = r_map[r];
  end

endmodule

/* source/spec_rename_map.sv */
/*
 * spec_rename_map
 * Speculative rename map of one register file. Looks up rs1 and the
 * old rd mapping per slot, forwards earlier slots' writes inside the
 * group and reloads from the commit map after a flush.
 */
`timescale 1ns/1ps

module spec_rename_map #(
  parameter rename_pkg::reg_typ_t REG_TYPE = rename_pkg::GPR,
  parameter type rnid_t = logic [rename_pkg::RNID_W-1:0]
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  rename_pkg::disp_grp_t i_disp,
  input  rnid_t                 i_new_rnid   [rename_pkg::DISP_SIZE],
  input  logic                  i_flush,
  input  rnid_t                 i_commit_map [rename_pkg::NUM_AREGS],
  output rnid_t                 o_rs1_rnid   [rename_pkg::DISP_SIZE],
  output rnid_t                 o_old_rnid   [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  rnid_t          r_map      [NUM_AREGS];
  rnid_t          w_map      [NUM_AREGS];   // map as seen this cycle.
  rnid_t          w_map_next [NUM_AREGS];
  logic           r_reload;
  grp_id_t        w_wr;

  // after a flush the commit map, which has just taken the flushing
  // group, stands in for the stored entries for one cycle.
  always_comb begin
    for (int r = 0; r < NUM_AREGS; r++) begin
      w_map[r] = r_reload ? i_commit_map[r] : r_map[r];
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr[d] = i_disp.valid && rd_write(i_disp.slot[d]) &&
                i_disp.slot[d].rd_typ == REG_TYPE;
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d] = w_map[i_disp.slot[d].rs1_regidx];
      o_old_rnid[d] = w_map[i_disp.slot[d].rd_regidx];
      for (int e = 0; e < d; e++) begin   // nearest older writer wins.
        if (w_wr[e] && i_disp.slot[d].rs1_typ == REG_TYPE &&
            i_disp.slot[d].rs1_regidx == i_disp.slot[e].rd_regidx) begin
          o_rs1_rnid[d] = i_new_rnid[e];
        end
        if (w_wr[e] && w_wr[d] &&
            i_disp.slot[d].rd_regidx == i_disp.slot[e].rd_regidx) begin
          o_old_rnid[d] = i_new_rnid[e];
        end
      end
    end
  end

  always_comb begin
    w_map_next = w_map;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_wr[d]) begin
        w_map_next[i_disp.slot[d].rd_regidx] = i_new_rnid[d];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_reload <= 1'b0;
    end else begin
      r_reload <= i_flush;
    end
  end

  for (genvar r = 0; r < NUM_AREGS; r++) begin : g_map
    if (REG_TYPE == GPR && r == 0) begin : g_zero
      assign r_map[r] = '0;
    end else begin : g_reg
      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_map[r] <= rnid_t'(r);
        end else begin
          r_map[r] <= w_map_next[r];
        end
      end
    end
  end

endmodule

/* source/rnid_free_list.sv */
/*
 * rnid_free_list
 * Circular list of free rnids for one register file. Allocation reads
 * at the allocation head, commit advances the commit head and pushes
 * the freed rnids at the tail, flush rewinds allocation.
 */
`timescale 1ns/1ps

module rnid_free_list #(
  parameter int                   RNID_SIZE = rename_pkg::XPR_RNID_SIZE,
  parameter rename_pkg::reg_typ_t REG_TYPE  = rename_pkg::GPR,
  parameter type rnid_t = logic [rename_pkg::RNID_W-1:0]
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rename_pkg::disp_grp_t     i_disp,
  input  rename_pkg::cmt_rnid_upd_t i_commit_rnid_update,
  input  logic                      i_flush,
  output rnid_t                     o_new_rnid [rename_pkg::DISP_SIZE],
  output logic                      o_low
);
  import rename_pkg::*;

  localparam int FL_SIZE = RNID_SIZE - NUM_AREGS;
  localparam int PTR_W   = $clog2(FL_SIZE);
  localparam int CNT_W   = $clog2(FL_SIZE + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  rnid_t   r_fifo [FL_SIZE];
  ptr_t    r_alloc_head;
  ptr_t    r_cmt_head;
  ptr_t    r_tail;
  cnt_t    r_avail;      // rnids between allocation head and tail.
  ptr_t    w_alloc_pos [DISP_SIZE];
  ptr_t    w_push_pos  [DISP_SIZE];
  rnid_t   w_push_rnid [DISP_SIZE];
  grp_id_t w_alloc;
  grp_id_t w_push;
  grp_id_t w_killed;
  cnt_t    w_alloc_cnt;
  cnt_t    w_push_cnt;

  function automatic ptr_t ptr_add(ptr_t p, cnt_t n);
    return ptr_t'((int'(p) + int'(n)) % FL_SIZE);
  endfunction

  always_comb begin
    w_killed    = killed(i_commit_rnid_update);
    w_alloc_cnt = '0;
    w_push_cnt  = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_alloc[d] = i_disp.valid && rd_write(i_disp.slot[d]) &&
                   i_disp.slot[d].rd_typ == REG_TYPE;
      w_push[d]  = i_commit_rnid_update.commit && i_commit_rnid_update.rnid_valid[d] &&
                   i_commit_rnid_update.rd_typ[d] == REG_TYPE;
      w_alloc_pos[d] = ptr_add(r_alloc_head, w_alloc_cnt);
      w_push_pos[d]  = ptr_add(r_tail, w_push_cnt);
      o_new_rnid[d]  = r_fifo[w_alloc_pos[d]];
      // a killed slot gives back its own rnid, a live one the replaced one.
      w_push_rnid[d] = w_killed[d] ? rnid_t'(i_commit_rnid_update.rd_rnid[d]) :
                                     rnid_t'(i_commit_rnid_update.old_rnid[d]);
      w_alloc_cnt = w_alloc_cnt + cnt_t'(w_alloc[d]);
      w_push_cnt  = w_push_cnt + cnt_t'(w_push[d]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_head <= '0;
      r_cmt_head   <= '0;
      r_tail       <= '0;
      r_avail      <= cnt_t'(FL_SIZE);
    end else begin
      r_cmt_head <= ptr_add(r_cmt_head, w_push_cnt);
      r_tail     <= ptr_add(r_tail, w_push_cnt);
      if (i_flush) begin
        r_alloc_head <= ptr_add(r_cmt_head, w_push_cnt);
        r_avail      <= cnt_t'(FL_SIZE);   // all uncommitted rnids are free again.
      end else begin
        r_alloc_head <= ptr_add(r_alloc_head, w_alloc_cnt);
        r_avail      <= r_avail - w_alloc_cnt + w_push_cnt;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FL_SIZE; i++) begin
        r_fifo[i] <= rnid_t'(NUM_AREGS + i);   // ascending after the identity map.
      end
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_push[d]) begin
          r_fifo[w_push_pos[d]] <= w_push_rnid[d];
        end
      end
    end
  end

  assign o_low = r_avail < cnt_t'(DISP_SIZE);

endmodule

/* source/commit_group_queue.sv */
/*
 * commit_group_queue
 * In-order FIFO of dispatched groups. The oldest group is merged with
 * the commit request into the commit update, and a trap flushes it.
 */
`timescale 1ns/1ps

module commit_group_queue (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rename_pkg::disp_grp_t     i_disp,
  input  rename_pkg::rnid_t         i_gpr_new_rnid [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t         i_gpr_old_rnid [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t         i_fpr_new_rnid [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t         i_fpr_old_rnid [rename_pkg::DISP_SIZE],
  input  rename_pkg::cmt_req_t      i_cmt,
  output rename_pkg::cmt_rnid_upd_t o_commit_rnid_update,
  output logic                      o_flush,
  output logic                      o_full
);
  import rename_pkg::*;

  localparam int PTR_W = $clog2(CQ_DEPTH);   // depth is a power of two.
  localparam int CNT_W = $clog2(CQ_DEPTH + 1);

  typedef struct packed {
    grp_id_t                   rnid_valid;
    reg_typ_t [DISP_SIZE-1:0] rd_typ;
    reg_idx_t [DISP_SIZE-1:0] rd_regidx;
    rnid_t [DISP_SIZE-1:0]    rd_rnid;
    rnid_t [DISP_SIZE-1:0]    old_rnid;
  } cq_entry_t;

  cq_entry_t        r_entry [CQ_DEPTH];
  cq_entry_t        w_new;
  cq_entry_t        w_head;
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_new.rnid_valid[d] = rd_write(i_disp.slot[d]);
      w_new.rd_typ[d]     = i_disp.slot[d].rd_typ;
      w_new.rd_regidx[d]  = i_disp.slot[d].rd_regidx;
      w_new.rd_rnid[d]    = (i_disp.slot[d].rd_typ == FPR) ? i_fpr_new_rnid[d] :
                                                             i_gpr_new_rnid[d];
      w_new.old_rnid[d]   = (i_disp.slot[d].rd_typ == FPR) ? i_fpr_old_rnid[d] :
                                                             i_gpr_old_rnid[d];
    end
  end

  assign w_head = r_entry[r_rd_ptr];

  always_comb begin
    o_commit_rnid_update.commit       = i_cmt.commit;
    o_commit_rnid_update.rnid_valid   = w_head.rnid_valid;
    o_commit_rnid_update.rd_typ       = w_head.rd_typ;
    o_commit_rnid_update.rd_regidx    = w_head.rd_regidx;
    o_commit_rnid_update.rd_rnid      = w_head.rd_rnid;
    o_commit_rnid_update.old_rnid     = w_head.old_rnid;
    o_commit_rnid_update.dead_id      = i_cmt.dead_id;
    o_commit_rnid_update.except_valid = i_cmt.except_valid;
    o_commit_rnid_update.except_type  = i_cmt.except_type;
  end

  assign o_flush = i_cmt.commit && (|i_cmt.except_valid) && i_cmt.except_type == TRAP;
  assign o_full  = r_count == CNT_W'(CQ_DEPTH);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (o_flush) begin
      r_wr_ptr <= '0;   // younger groups are squashed.
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      r_wr_ptr <= r_wr_ptr + PTR_W'(i_disp.valid);
      r_rd_ptr <= r_rd_ptr + PTR_W'(i_cmt.commit);
      r_count  <= r_count + CNT_W'(i_disp.valid) - CNT_W'(i_cmt.commit);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp.valid) begin
      r_entry[r_wr_ptr] <= w_new;
    end
  end

endmodule

/* source/rename_top.sv */
/*
 * rename_top
 * Register rename for a two-wide dispatch group. Wires the GPR and FPR
 * maps and free lists to the commit queue, registers the rename result
 * and raises the dispatch stall.
 */
`timescale 1ns/1ps

module rename_top (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  rename_pkg::disp_grp_t   i_disp,
  input  rename_pkg::cmt_req_t    i_cmt,
  output rename_pkg::rename_res_t o_rename,
  output logic                    o_disp_stall,
  output rename_pkg::rnid_t       o_gpr_commit_map [rename_pkg::NUM_AREGS],
  output rename_pkg::rnid_t       o_fpr_commit_map [rename_pkg::NUM_AREGS]
);
  import rename_pkg::*;

  disp_grp_t     w_disp;
  cmt_rnid_upd_t w_cmt_upd;
  rename_res_t   w_res;
  rename_res_t   r_rename;
  logic          w_flush;
  logic          w_cq_full;
  logic [1:0]    w_low;
  rnid_t         w_new     [2][DISP_SIZE];   // index 0 is GPR, 1 is FPR.
  rnid_t         w_old     [2][DISP_SIZE];
  rnid_t         w_rs1     [2][DISP_SIZE];
  rnid_t         w_cmt_map [2][NUM_AREGS];

  always_comb begin
    w_disp       = i_disp;
    w_disp.valid = i_disp.valid && !w_flush;   // dropped in a flush cycle.
  end

  for (genvar f = 0; f < 2; f++) begin : g_file
    localparam reg_typ_t TYP  = (f == 0) ? GPR : FPR;
    localparam int       SIZE = (f == 0) ? XPR_RNID_SIZE : FPR_RNID_SIZE;

    commit_map #(.REG_TYPE(TYP), .rnid_t(rnid_t)) u_commit_map (
      .i_clk, .i_reset_n, .i_commit_rnid_update(w_cmt_upd), .o_rnid_map(w_cmt_map[f])
    );

    spec_rename_map #(.REG_TYPE(TYP), .rnid_t(rnid_t)) u_spec_map (
      .i_clk, .i_reset_n, .i_disp(w_disp), .i_new_rnid(w_new[f]), .i_flush(w_flush),
      .i_commit_map(w_cmt_map[f]), .o_rs1_rnid(w_rs1[f]), .o_old_rnid(w_old[f])
    );

    rnid_free_list #(.RNID_SIZE(SIZE), .REG_TYPE(TYP), .rnid_t(rnid_t)) u_free_list (
      .i_clk, .i_reset_n, .i_disp(w_disp), .i_commit_rnid_update(w_cmt_upd),
      .i_flush(w_flush), .o_new_rnid(w_new[f]), .o_low(w_low[f])
    );
  end

  commit_group_queue u_cq (
    .i_clk, .i_reset_n, .i_disp(w_disp),
    .i_gpr_new_rnid(w_new[0]), .i_gpr_old_rnid(w_old[0]),
    .i_fpr_new_rnid(w_new[1]), .i_fpr_old_rnid(w_old[1]),
    .i_cmt, .o_commit_rnid_update(w_cmt_upd), .o_flush(w_flush), .o_full(w_cq_full)
  );

  always_comb begin
    w_res.valid = w_disp.valid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_res.rd_rnid[d] = !rd_write(w_disp.slot[d]) ? '0 :
                         (w_disp.slot[d].rd_typ == FPR) ? w_new[1][d] : w_new[0][d];
      case (w_disp.slot[d].rs1_typ)
        GPR:     w_res.rs1_rnid[d] = w_rs1[0][d];
        FPR:     w_res.rs1_rnid[d] = w_rs1[1][d];
        default: w_res.rs1_rnid[d] = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rename <= '0;
    end else begin
      r_rename <= w_res;
    end
  end

  assign o_rename         = r_rename;
  assign o_disp_stall     = (|w_low) || w_cq_full;
  assign o_gpr_commit_map = w_cmt_map[0];
  assign o_fpr_commit_map = w_cmt_map[1];

endmodule

/* testbench/tb_rename.sv */
/*
 * tb_rename
 * Testbench for the register-rename top level. Replays dispatch and
 * commit operations from a stimulus file and compares rename results,
 * commit-map entries and the dispatch stall with the file's values.
 */
`timescale 1ns/1ps

module tb_rename;
  import rename_pkg::*;

  localparam string STIM_FILE = "testbench/rename_input.txt";

  logic        clk;
  logic        reset_n;
  disp_grp_t   disp;
  cmt_req_t    cmt;
  rename_res_t res;
  logic        disp_stall;
  rnid_t       gpr_cmap [NUM_AREGS];
  rnid_t       fpr_cmap [NUM_AREGS];
  string       ops [$];                // one operation per entry.
  int          cycles = 0;
  int          cycle_limit = 1000;

  rename_top DUT (
    .i_clk(clk), .i_reset_n(reset_n), .i_disp(disp), .i_cmt(cmt),
    .o_rename(res), .o_disp_stall(disp_stall),
    .o_gpr_commit_map(gpr_cmap), .o_fpr_commit_map(fpr_cmap)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got == exp) else begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      abort_run("timeout: the stimulus did not finish within the cycle limit");
    end
  end

  task automatic load_ops();
    int    fd;
    string line;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line[0] != "#") begin   // skip blank and comment lines.
        ops.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // drives a one-cycle dispatch strobe and checks the result a cycle later.
  task automatic drive_dispatch(input string line);
    int f [12];
    int n;
    n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
    if (n != 12) begin
      abort_run({"malformed dispatch line: ", line});
    end
    assert (disp_stall == 1'b0) else begin
      abort_run("dispatch requested while o_disp_stall is high");
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      disp.slot[d].rd_typ     = reg_typ_t'(f[4*d]);
      disp.slot[d].rd_regidx  = reg_idx_t'(f[4*d+1]);
      disp.slot[d].rs1_typ    = reg_typ_t'(f[4*d+2]);
      disp.slot[d].rs1_regidx = reg_idx_t'(f[4*d+3]);
    end
    disp.valid = 1'b1;
    @(negedge clk);
    disp = '0;
    expect_equal("o_rename.valid", res.valid, 1);
    for (int d = 0; d < DISP_SIZE; d++) begin
      expect_equal($sformatf("o_rename.rd_rnid[%0d]", d), res.rd_rnid[d], f[8+2*d]);
      expect_equal($sformatf("o_rename.rs1_rnid[%0d]", d), res.rs1_rnid[d], f[9+2*d]);
    end
  endtask

  task automatic send_commit(input string line);
    int f [3];
    int n;
    n = $sscanf(line, "C %h %h %h", f[0], f[1], f[2]);
    if (n != 3) begin
      abort_run({"malformed commit line: ", line});
    end
    cmt.commit       = 1'b1;
    cmt.dead_id      = grp_id_t'(f[0]);
    cmt.except_valid = grp_id_t'(f[1]);
    cmt.except_type  = except_t'(f[2]);
    @(negedge clk);
    cmt = '0;
    expect_equal("o_rename.valid", res.valid, 0);   // no dispatch in the commit cycle.
  endtask

  // two entries of one commit map.
  task automatic probe_commit_map(input string line);
    int f [5];
    int n;
    int idx;
    n = $sscanf(line, "M %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
    if (n != 5) begin
      abort_run({"malformed map probe line: ", line});
    end
    for (int k = 0; k < 2; k++) begin
      idx = f[1+2*k];
      if (f[0] == 2) begin
        expect_equal($sformatf("o_fpr_commit_map[%0d]", idx), fpr_cmap[idx], f[2+2*k]);
      end else begin
        expect_equal($sformatf("o_gpr_commit_map[%0d]", idx), gpr_cmap[idx], f[2+2*k]);
      end
    end
  endtask

  task automatic sample_stall(input string line);
    int exp;
    if ($sscanf(line, "S %h", exp) != 1) begin
      abort_run({"malformed stall line: ", line});
    end
    expect_equal("o_disp_stall", disp_stall, exp);
  endtask

  initial begin
    reset_n = 1'b0;
    disp    = '0;
    cmt     = '0;
    load_ops();
    cycle_limit = ops.size() * 4 + 20;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    expect_equal("o_rename.valid", res.valid, 0);
    foreach (ops[i]) begin
      case (ops[i][0])
        "D":     drive_dispatch(ops[i]);
        "C":     send_commit(ops[i]);
        "M":     probe_commit_map(ops[i]);
        "S":     sample_stall(ops[i]);
        default: abort_run({"unknown operation in stimulus file: ", ops[i]});
      endcase
    end
    $display("All checks passed");
    $finish;
  end

endmodule

/* flist.f */
source/rename_pkg.sv
source/commit_map.sv
source/spec_rename_map.sv
source/rnid_free_list.sv
source/commit_group_queue.sv
source/rename_top.sv
testbench/tb_rename.sv

/* Bender.yml */
package:
  name: rename

sources:
  - source/rename_pkg.sv
  - source/commit_map.sv
  - source/spec_rename_map.sv
  - source/rnid_free_list.sv
  - source/commit_group_queue.sv
  - source/rename_top.sv
  - target: simulation
    files:
      - testbench/tb_rename.sv

/* testbench/rename_input.txt */
# D rd_typ rd_idx rs1_typ rs1_idx (slot 0, slot 1) exp_rd0 exp_rs1_0 exp_rd1 exp_rs1_1
# C dead_id except_valid except_type / M typ idx exp idx exp / S stall  (hex, typ 1 GPR 2 FPR)
S 0
M 1 0 0 5 5
M 2 0 0 1f 1f
D 1 5 1 5 1 6 1 5 20 5 21 20
D 2 3 2 3 2 4 2 3 20 3 21 20
D 1 0 1 0 1 7 1 0 0 0 22 0
C 0 0 0
M 1 5 20 6 21
M 2 5 5 6 6
C 2 0 0
M 2 3 20 4 4
D 1 5 1 6 2 3 1 5 23 21 22 23
C 0 2 2
M 1 7 7 5 20
D 1 8 1 5 2 5 2 3 23 20 22 20
C 0 1 1
M 1 8 23 5 20
M 2 5 22 3 20
D 2 1 2 5 2 2 2 1 23 22 24 23
D 2 1 2 1 2 1 2 2 25 23 26 24
D 2 6 0 0 2 7 1 8 27 0 3 23
S 0
D 2 8 2 6 1 9 2 7 21 27 24 3
S 1
C 0 0 0
M 2 1 23 2 24
S 0
C 0 0 0
M 2 1 26 2 24
D 2 9 2 1 2 a 2 9 5 26 1 5
D 0 0 1 5 0 0 2 1 0 20 0 26
D 0 0 2 3 0 0 1 0 0 20 0 0
D 0 0 1 6 0 0 2 2 0 21 0 24
D 0 0 2 9 0 0 1 8 0 5 0 23
D 0 0 1 5 0 0 2 1 0 20 0 26
S 1
C 0 0 0
M 2 6 27 7 3
S 0
D 2 b 2 a 2 c 1 5 2 1 23 20
S 1
